// ==== rv_pipe_core.f ====
source/rv_pkg.sv
source/inst_mem.sv
source/fetch_stage.sv
source/decode_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/retire_stage.sv
source/rv_pipe_core.sv
sim/retire_checker.sv
sim/tb_rv_pipe_core.sv

// ==== sim/retire_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module retire_checker
    import rv_pkg::*;
(
    input wire          clk,
    input wire          busy,
    input wire retire_t retire
);

    int      mismatch_count = 0;
    int      other_errors   = 0;
    word_t   model_regs [32];
    word_t   prog_mem [IMEM_DEPTH];
    retire_t expect_q [$];
    logic    busy_prev = 1'b0;
    logic    halt_prev = 1'b0;

    initial begin
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
    end

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t sra;
        // arithmetic shift fills with the sign bit
        sra = $signed(a) >>> b[4:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? sra : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // steps the ISA model by one instruction and never writes x0
    function automatic retire_t ref_step(input word_t pc, output word_t next_pc);
        word_t      inst;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      val;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       wr;
        logic       take;
        retire_t    r;
        inst    = prog_mem[pc[IMEM_AW+1:2]];
        f3      = inst[14:12];
        f7      = inst[31:25];
        a       = model_regs[inst[19:15]];
        b       = model_regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        wr      = 1'b0;
        val     = '0;
        take    = 1'b0;
        next_pc = pc + 32'd4;
        r       = '0;
        r.valid = 1'b1;
        r.pc    = pc;
        case (inst[6:0])
            OPC_OP: begin
                wr  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                val = alu_ref(f3, f7[5], a, b);
            end
            OPC_OP_IMM: begin
                if (f3 == 3'b001) begin
                    wr = (f7 == 7'h00);
                end else if (f3 == 3'b101) begin
                    wr = (f7 == 7'h00) || (f7 == 7'h20);
                end else begin
                    wr = 1'b1;
                end
                val = alu_ref(f3, f3 == 3'b101 && f7[5], a, imm_i);
            end
            OPC_LUI: begin
                wr  = 1'b1;
                val = {inst[31:12], 12'b0};
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) begin
                    next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                    inst[11:8], 1'b0};
                end
            end
            OPC_JAL: begin
                wr      = 1'b1;
                val     = pc + 32'd4;
                next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                inst[30:21], 1'b0};
            end
            OPC_SYSTEM: r.halt = (inst == 32'h0010_0073);
            default: ;
        endcase
        if (wr && inst[11:7] != 5'd0) begin
            model_regs[inst[11:7]] = val;
            r.rd   = inst[11:7];
            r.data = val;
        end
        return r;
    endfunction

    task automatic set_word(input int idx, input word_t data);
        prog_mem[idx] = data;
    endtask

    // expected trace of one run from PC 0 up to the EBREAK
    task automatic prepare_run(input int n);
        word_t   pc;
        word_t   next_pc;
        retire_t r;
        int      steps;
        pc    = '0;
        steps = 0;
        r     = '0;
        expect_q.delete();
        while (!r.halt && steps < n) begin
            r = ref_step(pc, next_pc);
            expect_q.push_back(r);
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t want);
        $display("MISMATCH %s: got %h, expected %h", name, got, want);
        mismatch_count++;
    endtask

    // compared on the falling edge while the retire register is stable
    always @(negedge clk) begin : compare_retire
        retire_t want;
        if (retire.valid === 1'b1) begin
            if (!busy) begin
                $display("instruction at pc %h retired while busy was low", retire.pc);
                other_errors++;
            end
            if (expect_q.size() == 0) begin
                $display("instruction at pc %h retired when none was due", retire.pc);
                other_errors++;
            end else begin
                want = expect_q.pop_front();
                if (retire.pc !== want.pc) begin
                    report_mismatch("retire.pc", retire.pc, want.pc);
                end
                if (retire.rd !== want.rd) begin
                    report_mismatch("retire.rd", retire.rd, want.rd);
                end
                if (want.rd != 5'd0 && retire.data !== want.data) begin
                    report_mismatch("retire.data", retire.data, want.data);
                end
                if (retire.halt !== want.halt) begin
                    report_mismatch("retire.halt", retire.halt, want.halt);
                end
            end
        end
        if (busy_prev && !busy && expect_q.size() != 0) begin
            $display("run ended before its halt, %0d instructions never retired",
                     expect_q.size());
            other_errors++;
        end
        // busy must be low in the cycle after the halt retires
        if (halt_prev && busy) begin
            $display("busy still high in the cycle after the halt retired");
            other_errors++;
        end
        halt_prev = (retire.valid === 1'b1) && (retire.halt === 1'b1);
        busy_prev = busy;
    end

endmodule

`default_nettype wire

// ==== sim/tb_rv_pipe_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_rv_pipe_core
    import rv_pkg::*;
();

    localparam int NUM_PROGRAMS = 10;

    logic        clk;
    logic        rst_n;
    logic        prog_we;
    imem_addr_t  prog_addr;
    word_t       prog_data;
    logic        run;
    logic        busy;
    retire_t     retire_out;
    logic [15:0] lfsr_state;
    word_t       program_words [IMEM_DEPTH];
    int          total_words = 0;
    int          cycle_count = 0;

    rv_pipe_core uut (
        .clk(clk), .rst_n(rst_n), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .run(run), .busy(busy), .retire(retire_out)
    );

    retire_checker chk (
        .clk(clk), .busy(busy), .retire(retire_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[15]};
        end
        return v;
    endfunction

    function automatic word_t branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // registers x0..x7 only, so dependent chains show up often
    task automatic build_program(output int n);
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [19:0] upper;
        int          k;
        n = 12 + int'(take_bits(4));
        for (int i = 0; i < n - 1; i++) begin
            kind  = take_bits(3);
            f3    = take_bits(3);
            rd    = take_bits(3);
            rs1   = take_bits(3);
            rs2   = take_bits(3);
            imm   = take_bits(12);
            upper = take_bits(20);
            // forward target, never past the closing EBREAK
            k = 1 + int'(take_bits(3)) % (n - 1 - i);
            case (kind)
                3'd0, 3'd1: begin
                    f7 = (take_bits(2) == 3) ? 7'h20 : 7'h00;
                    program_words[i] = {f7, rs2, rs1, f3, rd, OPC_OP};
                end
                3'd2, 3'd3: begin
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        imm[11:5] = (take_bits(1) != 0) ? 7'h20 : 7'h00;
                    end
                    program_words[i] = {imm, rs1, f3, rd, OPC_OP_IMM};
                end
                3'd4: program_words[i] = {upper, rd, OPC_LUI};
                3'd5: program_words[i] = branch_word(k * 4, rs2, rs1, f3);
                3'd6: program_words[i] = jal_word(k * 4, rd);
                default: begin
                    // a load or an ECALL, neither supported
                    if (take_bits(1) != 0) begin
                        program_words[i] = {imm, rs1, f3, rd, 7'b0000011};
                    end else begin
                        program_words[i] = 32'h0000_0073;
                    end
                end
            endcase
        end
        program_words[n-1] = 32'h0010_0073;
    endtask

    task automatic load_program(input int n);
        for (int i = 0; i < n; i++) begin
            prog_we   = 1'b1;
            prog_addr = i[IMEM_AW-1:0];
            prog_data = program_words[i];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
    endtask

    task automatic run_program();
        run = 1'b1;
        @(posedge clk);
        #1;
        run = 1'b0;
        while (!busy) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        // second pulse while busy must not restart the core
        if (busy) begin
            run = 1'b1;
            @(posedge clk);
            #1;
            run = 1'b0;
        end
        while (busy) begin
            @(posedge clk);
            #1;
        end
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_run(input logic timed_out);
        $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
                 chk.mismatch_count, chk.other_errors, timed_out);
        if (!timed_out && chk.mismatch_count == 0 && chk.other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 4 * total_words + 200) begin
            $display("timeout after %0d cycles, the core never went idle", cycle_count);
            finish_run(1'b1);
        end
    end

    initial begin
        int n;
        rst_n      = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        run        = 1'b0;
        lfsr_state = 16'd26;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // register state carries over from one program to the next
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            build_program(n);
            total_words += n;
            for (int i = 0; i < n; i++) begin
                chk.set_word(i, program_words[i]);
            end
            chk.prepare_run(n);
            load_program(n);
            run_program();
        end
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module decode_stage
    import rv_pkg::*;
(
    input wire          clk,
    input wire          rst_n,
    input wire          fetch_valid,
    input wire word_t   fetch_pc,
    input wire word_t   inst,
    input wire          flush,
    output reg_idx_t    rs1_idx,
    output reg_idx_t    rs2_idx,
    input wire word_t   rs1_data,
    input wire word_t   rs2_data,
    input wire retire_t ex_fwd,
    output decoded_t    decoded
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       op_legal;
    logic       imm_legal;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    word_t      rs1_val;
    word_t      rs2_val;
    decoded_t   dec_next;

    function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic sel_alt);
        alu_op_t op;
        case (f3)
            3'b000:  op = sel_alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = sel_alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct7[5] means SUB or SRA, for immediates only on the shift
    assign alt = funct7[5] && ((opcode == OPC_OP) || (funct3 == 3'b101));

    assign op_legal = (funct7 == 7'h00) ||
                      ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
    assign imm_legal = (funct3 == 3'b001) ? (funct7 == 7'h00) :
                       (funct3 == 3'b101) ? ((funct7 == 7'h00) || (funct7 == 7'h20)) : 1'b1;

    // value from execute first, the register file covers retire
    always_comb begin
        rs1_val = rs1_data;
        rs2_val = rs2_data;
        if (ex_fwd.valid && (ex_fwd.rd != '0) && (ex_fwd.rd == rs1_idx)) begin
            rs1_val = ex_fwd.data;
        end
        if (ex_fwd.valid && (ex_fwd.rd != '0) && (ex_fwd.rd == rs2_idx)) begin
            rs2_val = ex_fwd.data;
        end
    end

    always_comb begin
        dec_next           = '0;
        dec_next.pc        = fetch_pc;
        dec_next.rd        = inst[11:7];
        dec_next.alu_op    = alu_from_funct3(funct3, alt);
        dec_next.operand_a = rs1_val;
        dec_next.operand_b = rs2_val;
        dec_next.br_kind   = funct3;
        dec_next.imm       = imm_i;
        case (opcode)
            OPC_OP: begin
                dec_next.writes_rd = op_legal;
            end
            OPC_OP_IMM: begin
                dec_next.writes_rd = imm_legal;
                dec_next.operand_b = imm_i;
            end
            OPC_LUI: begin
                dec_next.writes_rd = 1'b1;
                dec_next.alu_op    = ALU_PASS_B;
                dec_next.operand_b = imm_u;
                dec_next.imm       = imm_u;
            end
            OPC_BRANCH: begin
                // funct3 010 and 011 are not branches
                dec_next.is_branch = (funct3[2:1] != 2'b01);
                dec_next.imm       = imm_b;
            end
            OPC_JAL: begin
                dec_next.writes_rd = 1'b1;
                dec_next.is_jal    = 1'b1;
                dec_next.imm       = imm_j;
            end
            OPC_SYSTEM: begin
                dec_next.is_halt = (inst == INST_EBREAK);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        decoded <= dec_next;
        if (!rst_n) begin
            decoded.valid <= 1'b0;
        end else begin
            decoded.valid <= fetch_valid && !flush;
        end
    end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module execute_stage
    import rv_pkg::*;
(
    input wire           clk,
    input wire           rst_n,
    input wire decoded_t decoded,
    output logic         redirect,
    output word_t        redirect_pc,
    output logic         halt_seen,
    output retire_t      ex_fwd,
    output retire_t      result
);

    word_t alu_out;
    word_t op_a;
    word_t op_b;
    logic  br_cond;
    logic  taken;

    assign op_a = decoded.operand_a;
    assign op_b = decoded.operand_b;

    always_comb begin
        case (decoded.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {31'b0, op_a < op_b};
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // branch compare on rs1 and rs2
    always_comb begin
        case (decoded.br_kind)
            F3_BEQ:  br_cond = (op_a == op_b);
            F3_BNE:  br_cond = (op_a != op_b);
            F3_BLT:  br_cond = ($signed(op_a) < $signed(op_b));
            F3_BGE:  br_cond = ($signed(op_a) >= $signed(op_b));
            F3_BLTU: br_cond = (op_a < op_b);
            F3_BGEU: br_cond = (op_a >= op_b);
            default: br_cond = 1'b0;
        endcase
    end

    assign taken       = decoded.is_branch && br_cond;
    assign redirect    = decoded.valid && (decoded.is_jal || taken);
    assign redirect_pc = decoded.pc + decoded.imm;
    assign halt_seen   = decoded.valid && decoded.is_halt;

    // also the forwarding value seen by decode
    always_comb begin
        ex_fwd.valid = decoded.valid;
        ex_fwd.pc    = decoded.pc;
        ex_fwd.rd    = decoded.writes_rd ? decoded.rd : '0;
        ex_fwd.data  = decoded.is_jal ? (decoded.pc + 32'd4) : alu_out;
        ex_fwd.halt  = decoded.is_halt;
    end

    always_ff @(posedge clk) begin
        result <= ex_fwd;
        if (!rst_n) begin
            result.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module fetch_stage
    import rv_pkg::*;
(
    input wire        clk,
    input wire        rst_n,
    input wire        run,
    input wire        redirect,
    input wire word_t redirect_pc,
    input wire        halt_seen,
    input wire        halt_retired,
    output logic      rd_en,
    output imem_addr_t rd_addr,
    output logic      fetch_valid,
    output word_t     fetch_pc,
    output logic      busy
);

    fetch_state_t state;
    word_t        pc;

    assign busy    = (state != FETCH_IDLE);
    assign rd_en   = (state == FETCH_RUN);
    assign rd_addr = pc[IMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= FETCH_IDLE;
            pc          <= '0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b0;
            case (state)
                FETCH_IDLE: begin
                    // every run starts at address 0
                    if (run) begin
                        state <= FETCH_RUN;
                        pc    <= '0;
                    end
                end
                FETCH_RUN: begin
                    if (halt_seen) begin
                        state <= FETCH_DRAIN;
                    end else if (redirect) begin
                        // word issued this cycle is dropped
                        pc <= redirect_pc;
                    end else begin
                        pc          <= pc + 32'd4;
                        fetch_valid <= 1'b1;
                    end
                end
                FETCH_DRAIN: begin
                    if (halt_retired) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // pc of the word now sitting in the memory read register
    always_ff @(posedge clk) begin
        fetch_pc <= pc;
    end

    a_no_redirect_idle: assert property (
        @(posedge clk) disable iff (!rst_n) (state == FETCH_IDLE) |-> !redirect
    ) else $error("fetch_stage: redirect while idle");

endmodule

`default_nettype wire

// ==== source/inst_mem.sv ====
`default_nettype none
`timescale 1ns/1ps

module inst_mem
    import rv_pkg::*;
(
    input wire             clk,
    input wire             prog_we,
    input wire imem_addr_t prog_addr,
    input wire word_t      prog_data,
    input wire             rd_en,
    input wire imem_addr_t rd_addr,
    output word_t          rd_data
);

    word_t mem [IMEM_DEPTH];

    // host side write port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // registered read, word appears in decode one cycle after issue
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // host loads only while the core is idle
    a_no_write_while_fetching: assert property (
        @(posedge clk) !(prog_we && rd_en)
    ) else $error("inst_mem: program write while fetch is reading");

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_file
    import rv_pkg::*;
(
    input wire           clk,
    input wire           rst_n,
    input wire reg_idx_t rs1_idx,
    input wire reg_idx_t rs2_idx,
    output word_t        rs1_data,
    output word_t        rs2_data,
    input wire           wr_en,
    input wire reg_idx_t wr_idx,
    input wire word_t    wr_data
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // write-through gives decode the value retiring this cycle
    assign rs1_data = (rs1_idx == '0) ? '0 :
                      (wr_en && (wr_idx == rs1_idx)) ? wr_data : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 :
                      (wr_en && (wr_idx == rs2_idx)) ? wr_data : regs[rs2_idx];

endmodule

`default_nettype wire

// ==== source/retire_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module retire_stage
    import rv_pkg::*;
(
    input wire          clk,
    input wire          rst_n,
    input wire retire_t result,
    output logic        wr_en,
    output reg_idx_t    wr_idx,
    output word_t       wr_data,
    output logic        halt_retired,
    output retire_t     retire
);

    // rd is already zero for anything that writes no register
    assign wr_en   = result.valid && (result.rd != '0);
    assign wr_idx  = result.rd;
    assign wr_data = result.data;

    assign halt_retired = result.valid && result.halt;

    // trace output, one strobe per completed instruction
    assign retire = result;

    // busy drops right after the halt, a new run needs at least four
    // cycles before anything can retire again
    a_halt_once_per_run: assert property (
        @(posedge clk) disable iff (!rst_n) halt_retired |=> !result.valid [*3]
    ) else $error("retire_stage: retire right after the halt");

endmodule

`default_nettype wire

// ==== source/rv_pipe_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module rv_pipe_core
    import rv_pkg::*;
(
    input wire             clk,
    input wire             rst_n,
    input wire             prog_we,
    input wire imem_addr_t prog_addr,
    input wire word_t      prog_data,
    input wire             run,
    output logic           busy,
    output retire_t        retire
);

    logic       rd_en;
    imem_addr_t rd_addr;
    word_t      inst;
    logic       fetch_valid;
    word_t      fetch_pc;
    logic       redirect;
    word_t      redirect_pc;
    logic       halt_seen;
    logic       halt_retired;
    logic       flush;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    word_t      rs1_data;
    word_t      rs2_data;
    decoded_t   decoded;
    retire_t    ex_fwd;
    retire_t    result;
    logic       wr_en;
    reg_idx_t   wr_idx;
    word_t      wr_data;

    // younger work dies on a taken branch, JAL or EBREAK
    assign flush = redirect | halt_seen;

    inst_mem u_inst_mem (
        .clk(clk), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(inst)
    );

    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n), .run(run),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .halt_seen(halt_seen), .halt_retired(halt_retired),
        .rd_en(rd_en), .rd_addr(rd_addr),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .busy(busy)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
        .inst(inst), .flush(flush), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .ex_fwd(ex_fwd), .decoded(decoded)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n), .decoded(decoded),
        .redirect(redirect), .redirect_pc(redirect_pc), .halt_seen(halt_seen),
        .ex_fwd(ex_fwd), .result(result)
    );

    retire_stage u_retire (
        .clk(clk), .rst_n(rst_n), .result(result),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .halt_retired(halt_retired), .retire(retire)
    );

endmodule

`default_nettype wire

// ==== source/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_IDX_W  = 5;
    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMEM_AW-1:0]   imem_addr_t;
    typedef logic [3:0]           alu_op_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;
    localparam alu_op_t ALU_SLTU   = 4'd6;
    localparam alu_op_t ALU_SLL    = 4'd7;
    localparam alu_op_t ALU_SRL    = 4'd8;
    localparam alu_op_t ALU_SRA    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // branch kinds, straight from funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam word_t INST_EBREAK = 32'h0010_0073;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_RUN,
        FETCH_DRAIN
    } fetch_state_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        reg_idx_t   rd;
        logic       writes_rd;
        alu_op_t    alu_op;
        word_t      operand_a;
        word_t      operand_b;
        logic       is_branch;
        logic [2:0] br_kind;
        logic       is_jal;
        logic       is_halt;
        word_t      imm;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    data;
        logic     halt;
    } retire_t;

endpackage

`default_nettype wire
